//--- Makefile
# Verilator build and run for the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/rob_enq_if.sv
`timescale 1ns/10ps

interface rob_enq_if;

    logic                write0;
    logic                write1;
    rob_pkg::rob_idx_t   slot;     // instr1 lands in slot + 1
    rob_pkg::pc_t        pc0;
    rob_pkg::pc_t        pc1;
    rob_pkg::instr_t     instr0;
    rob_pkg::instr_t     instr1;
    rob_pkg::lreg_t      lrd0;
    rob_pkg::lreg_t      lrd1;
    rob_pkg::preg_t      prd0;
    rob_pkg::preg_t      prd1;
    rob_pkg::preg_t      old_prd0;
    rob_pkg::preg_t      old_prd1;
    logic                need_to_wb0;
    logic                need_to_wb1;

    modport ctrl (output write0, write1, slot, pc0, pc1, instr0, instr1, lrd0, lrd1,
                  prd0, prd1, old_prd0, old_prd1, need_to_wb0, need_to_wb1);

    modport array (input write0, write1, slot, pc0, pc1, instr0, instr1, lrd0, lrd1,
                   prd0, prd1, old_prd0, old_prd1, need_to_wb0, need_to_wb1);

endinterface

//--- common/rob_pkg.sv
package rob_pkg;

    localparam int ROB_SIZE_LOG = 4;
    localparam int ROB_SIZE     = 1 << ROB_SIZE_LOG;

    typedef logic [ROB_SIZE_LOG-1:0] rob_idx_t;   // slot index
    typedef logic [ROB_SIZE_LOG:0]   rob_id_t;    // slot index plus wrap flag on top
    typedef logic [ROB_SIZE_LOG:0]   rob_count_t; // 0 to 16

    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  lreg_t;
    typedef logic [5:0]  preg_t;

    // rollback lasts one cycle, walk rebuilds the rename table
    typedef enum logic [1:0] {
        rob_idle     = 2'd0,
        rob_rollback = 2'd1,
        rob_walk     = 2'd2
    } rob_state_e;

endpackage

//--- common/rob_read_if.sv
`timescale 1ns/10ps

interface rob_read_if;

    rob_pkg::rob_idx_t index;
    logic              valid;
    logic              complete;
    logic              skip;
    rob_pkg::pc_t      pc;
    rob_pkg::instr_t   instr;
    rob_pkg::lreg_t    lrd;
    rob_pkg::preg_t    prd;
    rob_pkg::preg_t    old_prd;
    logic              need_to_wb;

    // fields come back in the same cycle
    modport reader (output index,
                    input valid, complete, skip, pc, instr, lrd, prd, old_prd, need_to_wb);

    modport array (input index,
                   output valid, complete, skip, pc, instr, lrd, prd, old_prd, need_to_wb);

endinterface

//--- hdl/rob_top.sv
`timescale 1ns/10ps

module rob_top (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 iq_can_alloc0,
    input  logic                 iq_can_alloc1,
    input  logic                 sq_can_alloc,
    input  logic                 instr0_enq_valid,
    input  rob_pkg::pc_t         instr0_pc,
    input  rob_pkg::instr_t      instr0,
    input  rob_pkg::lreg_t       instr0_lrd,
    input  rob_pkg::preg_t       instr0_prd,
    input  rob_pkg::preg_t       instr0_old_prd,
    input  logic                 instr0_need_to_wb,
    input  logic                 instr1_enq_valid,
    input  rob_pkg::pc_t         instr1_pc,
    input  rob_pkg::instr_t      instr1,
    input  rob_pkg::lreg_t       instr1_lrd,
    input  rob_pkg::preg_t       instr1_prd,
    input  rob_pkg::preg_t       instr1_old_prd,
    input  logic                 instr1_need_to_wb,
    output logic                 enq0_accept,
    output logic                 enq1_accept,
    output rob_pkg::rob_count_t  rob_counter,
    output rob_pkg::rob_id_t     instr_robid,
    input  logic                 intb_writeback0_valid,
    input  rob_pkg::rob_id_t     intb_writeback0_robid,
    input  logic                 intb_writeback1_valid,
    input  rob_pkg::rob_id_t     intb_writeback1_robid,
    input  logic                 memb_writeback0_valid,
    input  rob_pkg::rob_id_t     memb_writeback0_robid,
    input  logic                 memb_writeback0_mmio,
    output logic                 commit0_valid,
    output rob_pkg::pc_t         commit0_pc,
    output rob_pkg::instr_t      commit0_instr,
    output rob_pkg::lreg_t       commit0_lrd,
    output rob_pkg::preg_t       commit0_prd,
    output rob_pkg::preg_t       commit0_old_prd,
    output logic                 commit0_need_to_wb,
    output rob_pkg::rob_id_t     commit0_robid,
    output logic                 commit0_skip,
    input  logic                 flush_valid,
    input  rob_pkg::rob_id_t     flush_robid,   // held through the rollback cycle
    output rob_pkg::rob_state_e  rob_state,
    output logic                 rob_walk0_valid,
    output rob_pkg::lreg_t       rob_walk0_lrd,
    output rob_pkg::preg_t       rob_walk0_prd,
    output logic                 rob_walk0_complete,
    output logic                 rob_walk1_valid,
    output rob_pkg::lreg_t       rob_walk1_lrd,
    output rob_pkg::preg_t       rob_walk1_prd,
    output logic                 rob_walk1_complete
);

    logic [rob_pkg::ROB_SIZE-1:0]  kill_mask;
    logic [rob_pkg::ROB_SIZE-1:0]  commit_clear;
    rob_pkg::rob_id_t              enqueue_ptr;
    rob_pkg::rob_id_t              dequeue_ptr;

    rob_enq_if  enq ();
    rob_read_if head_rd ();
    rob_read_if walk0_rd ();
    rob_read_if walk1_rd ();

    rob_queue_ctrl queue_ctrl_i (.*);

    rob_entry_array entry_array_i (
        .intb_wb0_valid (intb_writeback0_valid),
        .intb_wb0_robid (intb_writeback0_robid),
        .intb_wb1_valid (intb_writeback1_valid),
        .intb_wb1_robid (intb_writeback1_robid),
        .memb_wb_valid  (memb_writeback0_valid),
        .memb_wb_robid  (memb_writeback0_robid),
        .memb_wb_mmio   (memb_writeback0_mmio),
        .*
    );

    rob_flush_walk flush_walk_i (.*);

endmodule

//--- rob/rob_entry.sv
`timescale 1ns/10ps

module rob_entry (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            write,
    input  rob_pkg::pc_t    write_pc,
    input  rob_pkg::instr_t write_instr,
    input  rob_pkg::lreg_t  write_lrd,
    input  rob_pkg::preg_t  write_prd,
    input  rob_pkg::preg_t  write_old_prd,
    input  logic            write_need_to_wb,
    input  logic            wb_complete,
    input  logic            wb_skip,
    input  logic            commit_clear,
    input  logic            kill,
    output logic            valid,
    output logic            complete,
    output logic            skip,
    output rob_pkg::pc_t    pc,
    output rob_pkg::instr_t instr,
    output rob_pkg::lreg_t  lrd,
    output rob_pkg::preg_t  prd,
    output rob_pkg::preg_t  old_prd,
    output logic            need_to_wb
);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid    <= 1'b0;
            complete <= 1'b0;
            skip     <= 1'b0;
        end else if (write) begin
            valid    <= 1'b1;
            complete <= 1'b0;  // fresh entry waits for writeback
            skip     <= 1'b0;
        end else begin
            if (commit_clear || kill) begin
                valid <= 1'b0;
            end
            if (valid && wb_complete) begin
                complete <= 1'b1;
            end
            if (valid && wb_skip) begin
                skip <= 1'b1;  // mmio access
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            pc         <= write_pc;
            instr      <= write_instr;
            lrd        <= write_lrd;
            prd        <= write_prd;
            old_prd    <= write_old_prd;
            need_to_wb <= write_need_to_wb;
        end
    end

endmodule

//--- rob/rob_entry_array.sv
`timescale 1ns/10ps

module rob_entry_array (
    input  logic                          clock,
    input  logic                          reset_n,
    rob_enq_if.array                      enq,
    input  logic                          intb_wb0_valid,
    input  rob_pkg::rob_id_t              intb_wb0_robid,
    input  logic                          intb_wb1_valid,
    input  rob_pkg::rob_id_t              intb_wb1_robid,
    input  logic                          memb_wb_valid,
    input  rob_pkg::rob_id_t              memb_wb_robid,
    input  logic                          memb_wb_mmio,
    input  logic [rob_pkg::ROB_SIZE-1:0]  kill_mask,
    input  logic [rob_pkg::ROB_SIZE-1:0]  commit_clear,
    rob_read_if.array                     head_rd,
    rob_read_if.array                     walk0_rd,
    rob_read_if.array                     walk1_rd
);

    rob_pkg::rob_idx_t               slot1;
    logic [rob_pkg::ROB_SIZE-1:0]    valid_v;
    logic [rob_pkg::ROB_SIZE-1:0]    complete_v;
    logic [rob_pkg::ROB_SIZE-1:0]    skip_v;
    logic [rob_pkg::ROB_SIZE-1:0]    need_to_wb_v;
    rob_pkg::pc_t                    pc_v      [rob_pkg::ROB_SIZE];
    rob_pkg::instr_t                 instr_v   [rob_pkg::ROB_SIZE];
    rob_pkg::lreg_t                  lrd_v     [rob_pkg::ROB_SIZE];
    rob_pkg::preg_t                  prd_v     [rob_pkg::ROB_SIZE];
    rob_pkg::preg_t                  old_prd_v [rob_pkg::ROB_SIZE];

    assign slot1 = enq.slot + 1'b1;  // wraps at 16

    for (genvar i = 0; i < rob_pkg::ROB_SIZE; i++) begin : g_entry
        logic sel0;
        logic sel1;
        logic mem_hit;
        logic wb_hit;

        assign sel0    = enq.write0 && (enq.slot == rob_pkg::rob_idx_t'(i));
        assign sel1    = enq.write1 && (slot1 == rob_pkg::rob_idx_t'(i));
        // only the index bits pick the entry
        assign mem_hit = memb_wb_valid &&
                         (memb_wb_robid[rob_pkg::ROB_SIZE_LOG-1:0] == rob_pkg::rob_idx_t'(i));
        assign wb_hit  = mem_hit ||
            (intb_wb0_valid && (intb_wb0_robid[rob_pkg::ROB_SIZE_LOG-1:0] == rob_pkg::rob_idx_t'(i))) ||
            (intb_wb1_valid && (intb_wb1_robid[rob_pkg::ROB_SIZE_LOG-1:0] == rob_pkg::rob_idx_t'(i)));

        rob_entry entry_i (
            .clock            (clock),
            .reset_n          (reset_n),
            .write            (sel0 || sel1),
            .write_pc         (sel1 ? enq.pc1 : enq.pc0),
            .write_instr      (sel1 ? enq.instr1 : enq.instr0),
            .write_lrd        (sel1 ? enq.lrd1 : enq.lrd0),
            .write_prd        (sel1 ? enq.prd1 : enq.prd0),
            .write_old_prd    (sel1 ? enq.old_prd1 : enq.old_prd0),
            .write_need_to_wb (sel1 ? enq.need_to_wb1 : enq.need_to_wb0),
            .wb_complete      (wb_hit),
            .wb_skip          (mem_hit && memb_wb_mmio),
            .commit_clear     (commit_clear[i]),
            .kill             (kill_mask[i]),
            .valid            (valid_v[i]),
            .complete         (complete_v[i]),
            .skip             (skip_v[i]),
            .pc               (pc_v[i]),
            .instr            (instr_v[i]),
            .lrd              (lrd_v[i]),
            .prd              (prd_v[i]),
            .old_prd          (old_prd_v[i]),
            .need_to_wb       (need_to_wb_v[i])
        );
    end

    // head read for commit
    assign head_rd.valid      = valid_v[head_rd.index];
    assign head_rd.complete   = complete_v[head_rd.index];
    assign head_rd.skip       = skip_v[head_rd.index];
    assign head_rd.pc         = pc_v[head_rd.index];
    assign head_rd.instr      = instr_v[head_rd.index];
    assign head_rd.lrd        = lrd_v[head_rd.index];
    assign head_rd.prd        = prd_v[head_rd.index];
    assign head_rd.old_prd    = old_prd_v[head_rd.index];
    assign head_rd.need_to_wb = need_to_wb_v[head_rd.index];

    // walk slot 0 and slot 1
    assign walk0_rd.valid      = valid_v[walk0_rd.index];
    assign walk0_rd.complete   = complete_v[walk0_rd.index];
    assign walk0_rd.skip       = skip_v[walk0_rd.index];
    assign walk0_rd.pc         = pc_v[walk0_rd.index];
    assign walk0_rd.instr      = instr_v[walk0_rd.index];
    assign walk0_rd.lrd        = lrd_v[walk0_rd.index];
    assign walk0_rd.prd        = prd_v[walk0_rd.index];
    assign walk0_rd.old_prd    = old_prd_v[walk0_rd.index];
    assign walk0_rd.need_to_wb = need_to_wb_v[walk0_rd.index];

    assign walk1_rd.valid      = valid_v[walk1_rd.index];
    assign walk1_rd.complete   = complete_v[walk1_rd.index];
    assign walk1_rd.skip       = skip_v[walk1_rd.index];
    assign walk1_rd.pc         = pc_v[walk1_rd.index];
    assign walk1_rd.instr      = instr_v[walk1_rd.index];
    assign walk1_rd.lrd        = lrd_v[walk1_rd.index];
    assign walk1_rd.prd        = prd_v[walk1_rd.index];
    assign walk1_rd.old_prd    = old_prd_v[walk1_rd.index];
    assign walk1_rd.need_to_wb = need_to_wb_v[walk1_rd.index];

endmodule

//--- rob/rob_flush_walk.sv
`timescale 1ns/10ps

module rob_flush_walk (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 flush_valid,
    input  rob_pkg::rob_id_t     enqueue_ptr,
    input  rob_pkg::rob_id_t     dequeue_ptr,
    output rob_pkg::rob_state_e  rob_state,
    rob_read_if.reader           walk0_rd,
    rob_read_if.reader           walk1_rd,
    output logic                 rob_walk0_valid,
    output rob_pkg::lreg_t       rob_walk0_lrd,
    output rob_pkg::preg_t       rob_walk0_prd,
    output logic                 rob_walk0_complete,
    output logic                 rob_walk1_valid,
    output rob_pkg::lreg_t       rob_walk1_lrd,
    output rob_pkg::preg_t       rob_walk1_prd,
    output logic                 rob_walk1_complete
);

    rob_pkg::rob_state_e  next_state;
    rob_pkg::rob_id_t     walking_ptr;
    rob_pkg::rob_count_t  remaining;   // survivors not yet walked
    logic                 walking;

    assign walking   = (rob_state == rob_pkg::rob_walk);
    assign remaining = enqueue_ptr - walking_ptr;

    always_comb begin
        next_state = rob_state;
        case (rob_state)
            rob_pkg::rob_idle: begin
                if (flush_valid) begin
                    next_state = rob_pkg::rob_rollback;
                end
            end
            rob_pkg::rob_rollback: begin
                next_state = rob_pkg::rob_walk;  // always exactly one cycle
            end
            rob_pkg::rob_walk: begin
                if (flush_valid) begin
                    next_state = rob_pkg::rob_rollback;
                end else if (remaining <= 2) begin
                    next_state = rob_pkg::rob_idle;
                end
            end
            default: next_state = rob_pkg::rob_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rob_state   <= rob_pkg::rob_idle;
            walking_ptr <= '0;
        end else begin
            rob_state <= next_state;
            if (rob_state == rob_pkg::rob_rollback) begin
                walking_ptr <= dequeue_ptr;  // walk from oldest
            end else if (walking) begin
                walking_ptr <= walking_ptr + 2'd2;
            end
        end
    end

    assign walk0_rd.index = walking_ptr[rob_pkg::ROB_SIZE_LOG-1:0];
    assign walk1_rd.index = walk0_rd.index + 1'b1;

    assign rob_walk0_valid    = walking && (remaining != 0) && walk0_rd.valid && walk0_rd.need_to_wb;
    assign rob_walk0_lrd      = walk0_rd.lrd;
    assign rob_walk0_prd      = walk0_rd.prd;
    assign rob_walk0_complete = walk0_rd.complete;

    assign rob_walk1_valid    = walking && (remaining > 1) && walk1_rd.valid && walk1_rd.need_to_wb;
    assign rob_walk1_lrd      = walk1_rd.lrd;
    assign rob_walk1_prd      = walk1_rd.prd;
    assign rob_walk1_complete = walk1_rd.complete;

endmodule

//--- rob/rob_queue_ctrl.sv
`timescale 1ns/10ps

module rob_queue_ctrl (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          instr0_enq_valid,
    input  logic                          instr1_enq_valid,
    input  logic                          iq_can_alloc0,
    input  logic                          iq_can_alloc1,
    input  logic                          sq_can_alloc,
    input  rob_pkg::pc_t                  instr0_pc,
    input  rob_pkg::instr_t               instr0,
    input  rob_pkg::lreg_t                instr0_lrd,
    input  rob_pkg::preg_t                instr0_prd,
    input  rob_pkg::preg_t                instr0_old_prd,
    input  logic                          instr0_need_to_wb,
    input  rob_pkg::pc_t                  instr1_pc,
    input  rob_pkg::instr_t               instr1,
    input  rob_pkg::lreg_t                instr1_lrd,
    input  rob_pkg::preg_t                instr1_prd,
    input  rob_pkg::preg_t                instr1_old_prd,
    input  logic                          instr1_need_to_wb,
    input  rob_pkg::rob_state_e           rob_state,
    input  rob_pkg::rob_id_t              flush_robid,
    rob_enq_if.ctrl                       enq,
    rob_read_if.reader                    head_rd,
    output logic                          enq0_accept,
    output logic                          enq1_accept,
    output rob_pkg::rob_id_t              instr_robid,
    output rob_pkg::rob_id_t              enqueue_ptr,
    output rob_pkg::rob_id_t              dequeue_ptr,
    output rob_pkg::rob_count_t           rob_counter,
    output logic [rob_pkg::ROB_SIZE-1:0]  kill_mask,
    output logic [rob_pkg::ROB_SIZE-1:0]  commit_clear,
    output logic                          commit0_valid,
    output rob_pkg::pc_t                  commit0_pc,
    output rob_pkg::instr_t               commit0_instr,
    output rob_pkg::lreg_t                commit0_lrd,
    output rob_pkg::preg_t                commit0_prd,
    output rob_pkg::preg_t                commit0_old_prd,
    output logic                          commit0_need_to_wb,
    output rob_pkg::rob_id_t              commit0_robid,
    output logic                          commit0_skip
);

    logic                 idle;
    logic                 rollback;
    rob_pkg::rob_count_t  enq_num;
    rob_pkg::rob_id_t     kill_start;
    rob_pkg::rob_count_t  kill_count;

    assign idle     = (rob_state == rob_pkg::rob_idle);
    assign rollback = (rob_state == rob_pkg::rob_rollback);

    // room for two keeps acceptance independent of instr1
    assign enq0_accept = instr0_enq_valid && iq_can_alloc0 && sq_can_alloc &&
                         idle && (rob_counter <= rob_pkg::ROB_SIZE - 2);
    assign enq1_accept = instr1_enq_valid && iq_can_alloc1 && enq0_accept;
    assign enq_num     = rob_pkg::rob_count_t'(enq0_accept) + rob_pkg::rob_count_t'(enq1_accept);
    assign instr_robid = enqueue_ptr;

    assign enq.write0      = enq0_accept;
    assign enq.write1      = enq1_accept;
    assign enq.slot        = enqueue_ptr[rob_pkg::ROB_SIZE_LOG-1:0];
    assign enq.pc0         = instr0_pc;
    assign enq.pc1         = instr1_pc;
    assign enq.instr0      = instr0;
    assign enq.instr1      = instr1;
    assign enq.lrd0        = instr0_lrd;
    assign enq.lrd1        = instr1_lrd;
    assign enq.prd0        = instr0_prd;
    assign enq.prd1        = instr1_prd;
    assign enq.old_prd0    = instr0_old_prd;
    assign enq.old_prd1    = instr1_old_prd;
    assign enq.need_to_wb0 = instr0_need_to_wb;
    assign enq.need_to_wb1 = instr1_need_to_wb;

    // commit straight off the head slot
    assign head_rd.index      = dequeue_ptr[rob_pkg::ROB_SIZE_LOG-1:0];
    assign commit0_valid      = idle && head_rd.valid && head_rd.complete;
    assign commit0_pc         = head_rd.pc;
    assign commit0_instr      = head_rd.instr;
    assign commit0_lrd        = head_rd.lrd;
    assign commit0_prd        = head_rd.prd;
    assign commit0_old_prd    = head_rd.old_prd;
    assign commit0_need_to_wb = head_rd.need_to_wb;
    assign commit0_robid      = dequeue_ptr;
    assign commit0_skip       = head_rd.skip;

    assign kill_start = flush_robid + 1'b1;
    assign kill_count = enqueue_ptr - kill_start;  // entries younger than the flush

    for (genvar i = 0; i < rob_pkg::ROB_SIZE; i++) begin : g_slot
        rob_pkg::rob_idx_t offset;  // distance from first killed slot

        assign offset          = rob_pkg::rob_idx_t'(i) - kill_start[rob_pkg::ROB_SIZE_LOG-1:0];
        assign kill_mask[i]    = rollback && ({1'b0, offset} < kill_count);
        assign commit_clear[i] = commit0_valid && (head_rd.index == rob_pkg::rob_idx_t'(i));
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enqueue_ptr <= '0;
            dequeue_ptr <= '0;
            rob_counter <= '0;
        end else if (rollback) begin
            enqueue_ptr <= kill_start;
            rob_counter <= kill_start - dequeue_ptr;  // survivors only
        end else begin
            enqueue_ptr <= enqueue_ptr + enq_num;
            dequeue_ptr <= dequeue_ptr + commit0_valid;
            rob_counter <= rob_counter + enq_num - commit0_valid;
        end
    end

endmodule

//--- testbench/rob_ref_model.svh
`ifndef ROB_REF_MODEL_SVH
`define ROB_REF_MODEL_SVH

// one queue per field, index 0 holds the oldest entry
rob_pkg::pc_t        m_pc[$];
rob_pkg::instr_t     m_instr[$];
rob_pkg::lreg_t      m_lrd[$];
rob_pkg::preg_t      m_prd[$];
rob_pkg::preg_t      m_old_prd[$];
logic                m_ntwb[$];
logic                m_done[$];
logic                m_skip[$];
rob_pkg::rob_id_t    m_head = '0;       // robid of the oldest entry
rob_pkg::rob_id_t    m_flush_id = '0;
rob_pkg::rob_state_e m_state = rob_pkg::rob_idle;
int                  m_walk_pos = 0;    // walk offset from head

function automatic rob_pkg::rob_id_t tail_robid();
    return m_head + rob_pkg::rob_id_t'(m_pc.size());
endfunction

function automatic void push_entry(input rob_pkg::pc_t pc, input rob_pkg::instr_t instr,
                                   input rob_pkg::lreg_t lrd, input rob_pkg::preg_t prd,
                                   input rob_pkg::preg_t old_prd, input logic ntwb);
    m_pc.push_back(pc);
    m_instr.push_back(instr);
    m_lrd.push_back(lrd);
    m_prd.push_back(prd);
    m_old_prd.push_back(old_prd);
    m_ntwb.push_back(ntwb);
    m_done.push_back(1'b0);
    m_skip.push_back(1'b0);
endfunction

function automatic void drop_entry(input int pos);
    m_pc.delete(pos);
    m_instr.delete(pos);
    m_lrd.delete(pos);
    m_prd.delete(pos);
    m_old_prd.delete(pos);
    m_ntwb.delete(pos);
    m_done.delete(pos);
    m_skip.delete(pos);
endfunction

function automatic void retire_head();
    drop_entry(0);
    m_head = m_head + 1'b1;
endfunction

function automatic void mark_written_back(input rob_pkg::rob_id_t id, input logic mmio);
    int off;
    off = int'(rob_pkg::rob_id_t'(id - m_head));
    if (off < m_pc.size()) begin
        m_done[off] = 1'b1;
        if (mmio) m_skip[off] = 1'b1;   // mmio entries are skipped at commit
    end
endfunction

// keep flush_robid and everything older
function automatic void drop_flushed();
    int keep;
    keep = int'(rob_pkg::rob_id_t'(m_flush_id + 1'b1 - m_head));
    while (m_pc.size() > keep) drop_entry(m_pc.size() - 1);
    m_walk_pos = 0;
endfunction

function automatic logic walk_expected(input int pos);
    if ((m_state != rob_pkg::rob_walk) || (pos >= m_pc.size())) return 1'b0;
    return m_ntwb[pos];
endfunction

`endif

//--- testbench/tb_rob.sv
`timescale 1ns/10ps

module tb_rob;

    logic clock = 1'b0;
    logic reset_n = 1'b0;
    logic iq_can_alloc0 = 1'b0, iq_can_alloc1 = 1'b0, sq_can_alloc = 1'b0;
    logic instr0_enq_valid = 1'b0, instr1_enq_valid = 1'b0;
    logic instr0_need_to_wb = 1'b0, instr1_need_to_wb = 1'b0;
    rob_pkg::pc_t    instr0_pc = '0, instr1_pc = '0;
    rob_pkg::instr_t instr0 = '0, instr1 = '0;
    rob_pkg::lreg_t  instr0_lrd = '0, instr1_lrd = '0;
    rob_pkg::preg_t  instr0_prd = '0, instr1_prd = '0, instr0_old_prd = '0, instr1_old_prd = '0;
    logic intb_writeback0_valid = 1'b0, intb_writeback1_valid = 1'b0;
    logic memb_writeback0_valid = 1'b0, memb_writeback0_mmio = 1'b0;
    rob_pkg::rob_id_t intb_writeback0_robid = '0, intb_writeback1_robid = '0;
    rob_pkg::rob_id_t memb_writeback0_robid = '0;
    logic flush_valid = 1'b0;
    rob_pkg::rob_id_t flush_robid = '0;

    logic enq0_accept, enq1_accept, commit0_valid, commit0_need_to_wb, commit0_skip;
    rob_pkg::rob_count_t rob_counter;
    rob_pkg::rob_id_t    instr_robid, commit0_robid;
    rob_pkg::pc_t        commit0_pc;
    rob_pkg::instr_t     commit0_instr;
    rob_pkg::lreg_t      commit0_lrd, rob_walk0_lrd, rob_walk1_lrd;
    rob_pkg::preg_t      commit0_prd, commit0_old_prd, rob_walk0_prd, rob_walk1_prd;
    rob_pkg::rob_state_e rob_state;
    logic rob_walk0_valid, rob_walk0_complete, rob_walk1_valid, rob_walk1_complete;

    integer seed = 32'hbea6;
    int     errors = 0;
    int     timeouts = 0;
    logic   allow_enq = 1'b1;
    logic   allow_wb = 1'b1;
    logic   allow_flush = 1'b1;
    logic   saw_full = 1'b0;   // a full buffer turned away a ready instr0

    `include "rob_ref_model.svh"

    rob_top dut_i (.*);

    always #50 clock = ~clock;

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // called on the rising edge, fresh inputs for the coming cycle
    task automatic drive_cycle();
        int   live;
        int   span;
        logic flush;
        logic wb_ok;
        live  = m_pc.size();
        span  = (live > 0) ? live : 1;
        flush = allow_flush && (m_state != rob_pkg::rob_rollback) && (live > 0) && (pick(20) == 0);
        wb_ok = allow_wb && !flush && (m_state == rob_pkg::rob_idle) && (live > 0);
        flush_valid <= flush;
        if (flush) begin
            flush_robid <= m_head + rob_pkg::rob_id_t'(pick(live));  // stays through rollback
        end
        instr0_enq_valid      <= allow_enq && !flush && (pick(4) != 0);
        instr1_enq_valid      <= (pick(3) != 0);
        iq_can_alloc0         <= (pick(8) != 0);
        iq_can_alloc1         <= (pick(8) != 0);
        sq_can_alloc          <= (pick(8) != 0);
        instr0_pc             <= $random(seed);
        instr1_pc             <= $random(seed);
        instr0                <= $random(seed);
        instr1                <= $random(seed);
        instr0_lrd            <= rob_pkg::lreg_t'(pick(32));
        instr1_lrd            <= rob_pkg::lreg_t'(pick(32));
        instr0_prd            <= rob_pkg::preg_t'(pick(64));
        instr1_prd            <= rob_pkg::preg_t'(pick(64));
        instr0_old_prd        <= rob_pkg::preg_t'(pick(64));
        instr1_old_prd        <= rob_pkg::preg_t'(pick(64));
        instr0_need_to_wb     <= (pick(4) != 0);
        instr1_need_to_wb     <= (pick(4) != 0);
        intb_writeback0_valid <= wb_ok && (pick(2) == 0);
        intb_writeback1_valid <= wb_ok && (pick(2) == 0);
        memb_writeback0_valid <= wb_ok && (pick(3) == 0);
        memb_writeback0_mmio  <= (pick(4) == 0);
        intb_writeback0_robid <= m_head + rob_pkg::rob_id_t'(pick(span));
        intb_writeback1_robid <= m_head + rob_pkg::rob_id_t'(pick(span));
        memb_writeback0_robid <= m_head + rob_pkg::rob_id_t'(pick(span));
    endtask

    // sampled mid-cycle, then the model takes the coming edge
    task automatic check_cycle();
        logic acc0;
        logic acc1;
        logic commit;
        logic w0;
        logic w1;
        acc0   = instr0_enq_valid && iq_can_alloc0 && sq_can_alloc &&
                 (m_state == rob_pkg::rob_idle) && (m_pc.size() <= 14);
        acc1   = acc0 && instr1_enq_valid && iq_can_alloc1;
        commit = ((m_state == rob_pkg::rob_idle) && (m_pc.size() > 0)) ? m_done[0] : 1'b0;
        w0     = walk_expected(m_walk_pos);
        w1     = walk_expected(m_walk_pos + 1);
        if ((m_pc.size() >= 15) && instr0_enq_valid && iq_can_alloc0 && sq_can_alloc &&
            (m_state == rob_pkg::rob_idle)) begin
            saw_full = 1'b1;
        end
        check("rob_state", m_state, rob_state);
        check("rob_counter", m_pc.size(), rob_counter);
        check("instr_robid", tail_robid(), instr_robid);
        check("enq0_accept", acc0, enq0_accept);
        check("enq1_accept", acc1, enq1_accept);
        check("commit0_valid", commit, commit0_valid);
        if (commit) begin
            check("commit0_robid", m_head, commit0_robid);
            check("commit0_pc", m_pc[0], commit0_pc);
            check("commit0_instr", m_instr[0], commit0_instr);
            check("commit0_lrd", m_lrd[0], commit0_lrd);
            check("commit0_prd", m_prd[0], commit0_prd);
            check("commit0_old_prd", m_old_prd[0], commit0_old_prd);
            check("commit0_need_to_wb", m_ntwb[0], commit0_need_to_wb);
            check("commit0_skip", m_skip[0], commit0_skip);
        end
        check("rob_walk0_valid", w0, rob_walk0_valid);
        check("rob_walk1_valid", w1, rob_walk1_valid);
        if (w0) begin
            check("rob_walk0_lrd", m_lrd[m_walk_pos], rob_walk0_lrd);
            check("rob_walk0_prd", m_prd[m_walk_pos], rob_walk0_prd);
            check("rob_walk0_complete", m_done[m_walk_pos], rob_walk0_complete);
        end
        if (w1) begin
            check("rob_walk1_lrd", m_lrd[m_walk_pos + 1], rob_walk1_lrd);
            check("rob_walk1_prd", m_prd[m_walk_pos + 1], rob_walk1_prd);
            check("rob_walk1_complete", m_done[m_walk_pos + 1], rob_walk1_complete);
        end
        case (m_state)
            rob_pkg::rob_idle: begin
                if (intb_writeback0_valid) mark_written_back(intb_writeback0_robid, 1'b0);
                if (intb_writeback1_valid) mark_written_back(intb_writeback1_robid, 1'b0);
                if (memb_writeback0_valid) begin
                    mark_written_back(memb_writeback0_robid, memb_writeback0_mmio);
                end
                if (commit) retire_head();
                if (acc0) begin
                    push_entry(instr0_pc, instr0, instr0_lrd, instr0_prd, instr0_old_prd,
                               instr0_need_to_wb);
                end
                if (acc1) begin
                    push_entry(instr1_pc, instr1, instr1_lrd, instr1_prd, instr1_old_prd,
                               instr1_need_to_wb);
                end
                if (flush_valid) begin
                    m_flush_id = flush_robid;
                    m_state    = rob_pkg::rob_rollback;
                end
            end
            rob_pkg::rob_rollback: begin
                drop_flushed();
                m_state = rob_pkg::rob_walk;
            end
            default: begin
                if (flush_valid) begin
                    m_flush_id = flush_robid;
                    m_state    = rob_pkg::rob_rollback;
                end else if (m_pc.size() - m_walk_pos <= 2) begin
                    m_state = rob_pkg::rob_idle;   // last pair walked
                end
                m_walk_pos += 2;
            end
        endcase
    endtask

    task automatic run_cycle();
        drive_cycle();
        @(negedge clock);
        check_cycle();
        @(posedge clock);
    endtask

    initial begin
        int waited;
        repeat (2) @(posedge clock);
        @(negedge clock);
        check("reset rob_state", rob_pkg::rob_idle, rob_state);
        check("reset rob_counter", 0, rob_counter);
        check("reset commit0_valid", 0, commit0_valid);
        check("reset enq0_accept", 0, enq0_accept);
        check("reset enq1_accept", 0, enq1_accept);
        check("reset rob_walk0_valid", 0, rob_walk0_valid);
        check("reset rob_walk1_valid", 0, rob_walk1_valid);
        @(posedge clock);
        reset_n <= 1'b1;
        for (int cycle = 0; cycle < 1500; cycle++) begin
            allow_wb    = (cycle < 400) || (cycle >= 460);  // window to fill the buffer
            allow_flush = allow_wb;
            run_cycle();
        end
        allow_enq   = 1'b0;
        allow_flush = 1'b0;
        allow_wb    = 1'b1;
        waited      = 0;
        while (((m_pc.size() != 0) || (m_state != rob_pkg::rob_idle)) && (waited < 300)) begin
            run_cycle();
            waited++;
        end
        if ((m_pc.size() != 0) || (m_state != rob_pkg::rob_idle)) begin
            timeouts++;
            $display("timeout: buffer still holds entries after %0d drain cycles", waited);
        end
        check("fullness reached", 1'b1, saw_full);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+testbench
common/rob_pkg.sv
common/rob_enq_if.sv
common/rob_read_if.sv
rob/rob_entry.sv
rob/rob_entry_array.sv
rob/rob_queue_ctrl.sv
rob/rob_flush_walk.sv
hdl/rob_top.sv
testbench/tb_rob.sv
